/* logic/fgen_types_pkg.sv */
/* Datapath types for the waveform generator: samples, words, addresses,
   the playback FSM states and the control register map. */
package fgen_types_pkg;

	// one output sample and one host-side word
	typedef logic [7:0] sample_t;
	typedef logic [31:0] word_t;

	// sample index, four samples per memory word
	typedef logic [11:0] sample_addr_t;
	typedef logic [9:0] word_addr_t;

	typedef enum logic {
		idle,
		run
	} seq_state_t;

	// --------------------
	// control register map on chip select 0
	localparam logic [1:0] reg_start = 2'd0;
	localparam logic [1:0] reg_end = 2'd1;
	localparam logic [1:0] reg_enable = 2'd2;

endpackage

/* logic/spi_frame_pkg.sv */
/* SPI frame layout shared by the peripherals and their targets.
   A frame is an 8-bit command, a 16-bit address and 32 data bits, MSB first. */
package spi_frame_pkg;

	typedef logic [7:0] spi_cmd_t;
	typedef logic [15:0] spi_addr_t;
	typedef logic [31:0] spi_data_t;

	// commands, anything else is ignored by the targets
	localparam spi_cmd_t cmd_write = 8'h01;
	localparam spi_cmd_t cmd_read = 8'h02;

	// --------------------
	// frame geometry in bits
	localparam int header_bits = 24;
	localparam int frame_bits = 56;

	// one transaction as handed to a target
	typedef struct packed {
		spi_cmd_t cmd;
		spi_addr_t addr;
		spi_data_t data;
	} spi_txn_t;

endpackage

/* logic/spi_peripheral.sv */
/* SPI peripheral for one chip select. Deserializes 56-bit frames, passes them to a
   target over a four-phase req/ack handshake and shifts read data back on MISO. */
`timescale 1ns/1ps

module spi_peripheral
	import spi_frame_pkg::*, fgen_types_pkg::*;
(
	input logic word_clock,
	input logic reset3_word_clock,
	input logic sclk,
	input logic mosi,
	input logic ssel,
	output logic miso,
	output spi_txn_t txn,
	output logic req,
	input logic ack,
	input word_t read_data
);

	// pin synchronizers, third stage only for edge detection
	logic [2:0] sclk_sync;
	logic [1:0] mosi_sync;
	logic [2:0] ssel_sync;

	logic [frame_bits-1:0] shift_in;
	logic [5:0] bit_count;
	word_t out_shift;

	logic sclk_rise;
	logic sclk_fall;
	logic active;
	logic frame_end;
	logic read_start;
	logic write_start;
	logic [header_bits-1:0] header_next;

	assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
	assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
	assign active = ~ssel_sync[1];
	assign frame_end = ssel_sync[1] & ~ssel_sync[2];
	assign header_next = {shift_in[header_bits-2:0], mosi_sync[1]};

	// read goes out right after the 24th bit, write waits for chip select to rise
	assign read_start = active && sclk_rise && (bit_count == header_bits - 1)
		&& (header_next[header_bits-1 -: 8] == cmd_read);
	assign write_start = frame_end && (bit_count == frame_bits)
		&& (shift_in[frame_bits-1 -: 8] == cmd_write);

	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			sclk_sync <= '0;
			mosi_sync <= '0;
			ssel_sync <= '1;
		end else begin
			sclk_sync <= {sclk_sync[1:0], sclk};
			mosi_sync <= {mosi_sync[0], mosi};
			ssel_sync <= {ssel_sync[1:0], ssel};
		end
	end

	// --------------------
	// receive side
	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			bit_count <= '0;
		end else if (!active) begin
			bit_count <= '0;
		end else if (sclk_rise && (bit_count < frame_bits)) begin
			bit_count <= bit_count + 1'b1;
		end
	end

	always_ff @(posedge word_clock) begin
		if (active && sclk_rise) begin
			shift_in <= {shift_in[frame_bits-2:0], mosi_sync[1]};
		end
	end

	// --------------------
	// handshake, txn held while req is up
	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			req <= 1'b0;
		end else if (req) begin
			if (ack) begin
				req <= 1'b0;
			end
		end else if (read_start || write_start) begin
			req <= 1'b1;
		end
	end

	always_ff @(posedge word_clock) begin
		if (!req && read_start) begin
			txn <= spi_txn_t'({header_next, {$bits(spi_data_t){1'b0}}});
		end else if (!req && write_start) begin
			txn <= spi_txn_t'(shift_in);
		end
	end

	// --------------------
	// transmit side, MSB first on falling edges of the data phase
	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			out_shift <= '0;
			miso <= 1'b0;
		end else if (!active) begin
			out_shift <= '0;
			miso <= 1'b0;
		end else if (req && ack && (txn.cmd == cmd_read)) begin
			out_shift <= read_data;
		end else if (sclk_fall && (bit_count >= header_bits)) begin
			miso <= out_shift[31];
			out_shift <= {out_shift[30:0], 1'b0};
		end
	end

endmodule

/* logic/control_registers.sv */
/* Control registers behind chip select 0: playback start, playback end and run
   enable. Answers one req/ack transaction at a time. */
`timescale 1ns/1ps

module control_registers
	import fgen_types_pkg::*, spi_frame_pkg::*;
(
	input logic word_clock,
	input logic reset3_word_clock,
	input spi_txn_t txn,
	input logic req,
	output logic ack,
	output word_t read_data,
	output sample_addr_t start_sample,
	output sample_addr_t end_sample,
	output logic enable
);

	logic [1:0] reg_index;
	logic access;
	word_t reg_word;

	assign reg_index = txn.addr[1:0];
	// one access per handshake, on the cycle req is first seen
	assign access = req && !ack;

	// readback mux, address 3 reads 0
	always_comb begin
		case (reg_index)
			reg_start: reg_word = word_t'(start_sample);
			reg_end: reg_word = word_t'(end_sample);
			reg_enable: reg_word = word_t'(enable);
			default: reg_word = '0;
		endcase
	end

	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			ack <= 1'b0;
			start_sample <= '0;
			end_sample <= '0;
			enable <= 1'b0;
		end else begin
			ack <= req;
			if (access && (txn.cmd == cmd_write)) begin
				case (reg_index)
					reg_start: start_sample <= sample_addr_t'(txn.data);
					reg_end: end_sample <= sample_addr_t'(txn.data);
					reg_enable: enable <= txn.data[0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge word_clock) begin
		if (access && (txn.cmd == cmd_read)) begin
			read_data <= reg_word;
		end
	end

endmodule

/* logic/waveform_memory.sv */
/* Waveform memory: 32-bit words written and read over SPI on one port, single
   8-bit samples read by the playback sequencer on the other. */
`timescale 1ns/1ps

module waveform_memory
	import fgen_types_pkg::*, spi_frame_pkg::*;
#(
	parameter int SAMPLE_ADDR_WIDTH = 12
) (
	input logic word_clock,
	input logic reset3_word_clock,
	input spi_txn_t txn,
	input logic req,
	output logic ack,
	output word_t read_data,
	input sample_addr_t play_addr,
	output sample_t play_sample
);

	localparam int WORDS = 2 ** (SAMPLE_ADDR_WIDTH - 2);

	word_t mem [WORDS];

	word_addr_t host_word;
	word_addr_t play_word;
	logic [1:0] play_lane;
	logic access;

	assign host_word = txn.addr[$bits(word_addr_t)-1:0];
	assign play_word = play_addr[SAMPLE_ADDR_WIDTH-1:2];
	// byte 0 of a word sits in the top lane
	assign play_lane = 2'd3 - play_addr[1:0];
	assign access = req && !ack;

	// --------------------
	// host port
	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			ack <= 1'b0;
		end else begin
			ack <= req;
		end
	end

	always_ff @(posedge word_clock) begin
		if (access && (txn.cmd == cmd_write)) begin
			mem[host_word] <= txn.data;
		end
		if (access && (txn.cmd == cmd_read)) begin
			read_data <= mem[host_word];
		end
	end

	// --------------------
	// playback port, one cycle read
	always_ff @(posedge word_clock) begin
		play_sample <= mem[play_word][8*play_lane +: 8];
	end

endmodule

/* logic/playback_sequencer.sv */
/* Playback sequencer: loops the sample address from start to end minus one while
   enabled and emits the samples with a sync pulse on the first of each pass. */
`timescale 1ns/1ps

module playback_sequencer
	import fgen_types_pkg::*;
#(
	parameter int SAMPLE_ADDR_WIDTH = 12
) (
	input logic word_clock,
	input logic reset3_word_clock,
	input logic enable,
	input sample_addr_t start_sample,
	input sample_addr_t end_sample,
	output sample_addr_t play_addr,
	input sample_t play_sample,
	output sample_t sample,
	output logic sync
);

	seq_state_t state_q;
	sample_addr_t last_q;
	logic [SAMPLE_ADDR_WIDTH:0] next_addr;
	logic wrap;

	logic sync_raw;
	logic sync_d1;
	logic sync_q;
	logic run_d1;
	sample_t sample_q;

	// extra bit so an end at the top of the range still compares right
	assign next_addr = {1'b0, play_addr} + 1'b1;
	assign wrap = next_addr >= {1'b0, last_q};

	// --------------------
	// address loop, start and end only picked up at wrap
	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			state_q <= idle;
			play_addr <= '0;
			last_q <= '0;
			sync_raw <= 1'b0;
		end else begin
			sync_raw <= 1'b0;
			if (!enable) begin
				state_q <= idle;
			end else if ((state_q == idle) || wrap) begin
				state_q <= run;
				play_addr <= start_sample;
				last_q <= end_sample;
				sync_raw <= 1'b1;
			end else begin
				play_addr <= play_addr + 1'b1;
			end
		end
	end

	// --------------------
	// memory read stage, then output register
	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			sync_d1 <= 1'b0;
			sync_q <= 1'b0;
			run_d1 <= 1'b0;
			sample_q <= '0;
		end else begin
			sync_d1 <= sync_raw;
			sync_q <= sync_d1;
			run_d1 <= (state_q == run);
			sample_q <= run_d1 ? play_sample : '0;
		end
	end

	// outputs go quiet as soon as enable drops
	assign sample = enable ? sample_q : '0;
	assign sync = enable & sync_q;

endmodule

/* logic/function_generator_top.sv */
/* Top level of the SPI-controlled waveform generator. Chip select 0 reaches the
   control registers, chip select 1 the waveform memory; playback runs on word_clock. */
`timescale 1ns/1ps

module function_generator_top
	import fgen_types_pkg::*, spi_frame_pkg::*;
#(
	parameter int SAMPLE_ADDR_WIDTH = 12
) (
	input logic word_clock,
	input logic reset3_word_clock,
	input logic spi_sclk,
	input logic spi_mosi,
	input logic spi_ce0,
	input logic spi_ce1,
	output logic spi_miso,
	output sample_t sample,
	output logic sync
);

	spi_txn_t txn_ce0;
	spi_txn_t txn_ce1;
	logic req_ce0;
	logic req_ce1;
	logic ack_ce0;
	logic ack_ce1;
	word_t read_data_ce0;
	word_t read_data_ce1;
	logic miso_ce0;
	logic miso_ce1;

	sample_addr_t start_sample;
	sample_addr_t end_sample;
	sample_addr_t play_addr;
	sample_t play_sample;
	logic enable;

	// --------------------
	// chip select 0, control registers
	spi_peripheral u_spi_ce0 (
		.word_clock(word_clock),
		.reset3_word_clock(reset3_word_clock),
		.sclk(spi_sclk),
		.mosi(spi_mosi),
		.ssel(spi_ce0),
		.miso(miso_ce0),
		.txn(txn_ce0),
		.req(req_ce0),
		.ack(ack_ce0),
		.read_data(read_data_ce0)
	);

	control_registers u_regs (
		.word_clock(word_clock),
		.reset3_word_clock(reset3_word_clock),
		.txn(txn_ce0),
		.req(req_ce0),
		.ack(ack_ce0),
		.read_data(read_data_ce0),
		.start_sample(start_sample),
		.end_sample(end_sample),
		.enable(enable)
	);

	// --------------------
	// chip select 1, waveform memory
	spi_peripheral u_spi_ce1 (
		.word_clock(word_clock),
		.reset3_word_clock(reset3_word_clock),
		.sclk(spi_sclk),
		.mosi(spi_mosi),
		.ssel(spi_ce1),
		.miso(miso_ce1),
		.txn(txn_ce1),
		.req(req_ce1),
		.ack(ack_ce1),
		.read_data(read_data_ce1)
	);

	waveform_memory #(
		.SAMPLE_ADDR_WIDTH(SAMPLE_ADDR_WIDTH)
	) u_mem (
		.word_clock(word_clock),
		.reset3_word_clock(reset3_word_clock),
		.txn(txn_ce1),
		.req(req_ce1),
		.ack(ack_ce1),
		.read_data(read_data_ce1),
		.play_addr(play_addr),
		.play_sample(play_sample)
	);

	// --------------------
	playback_sequencer #(
		.SAMPLE_ADDR_WIDTH(SAMPLE_ADDR_WIDTH)
	) u_seq (
		.word_clock(word_clock),
		.reset3_word_clock(reset3_word_clock),
		.enable(enable),
		.start_sample(start_sample),
		.end_sample(end_sample),
		.play_addr(play_addr),
		.play_sample(play_sample),
		.sample(sample),
		.sync(sync)
	);

	// chip select 0 owns MISO while it is low
	assign spi_miso = !spi_ce0 ? miso_ce0 : miso_ce1;

endmodule

/* testbench/function_generator_chk.sv */
/* Concurrent checks on the req/ack handshake and the playback outputs.
   Bound into each SPI peripheral and into the sequencer; unused inputs are tied off. */
`timescale 1ns/1ps

module function_generator_chk
	import spi_frame_pkg::*;
(
	input logic word_clock,
	input logic reset3_word_clock,
	input logic req,
	input logic ack,
	input spi_txn_t txn,
	input logic enable,
	input logic sync
);

	// --------------------
	// four-phase handshake
	ack_after_req: assert property (@(posedge word_clock) disable iff (reset3_word_clock)
		$rose(ack) |-> req)
		else $error("ack rose while req was low");

	req_held: assert property (@(posedge word_clock) disable iff (reset3_word_clock)
		(req && !ack) |=> req)
		else $error("req dropped before ack");

	txn_stable: assert property (@(posedge word_clock) disable iff (reset3_word_clock)
		req |=> (!req || $stable(txn)))
		else $error("txn changed while req was high");

	// --------------------
	// outputs quiet when stopped
	// sync only once enable has been high for the playback latency
	sync_needs_enable: assert property (@(posedge word_clock) disable iff (reset3_word_clock)
		sync |-> (enable && $past(enable) && $past(enable, 2)))
		else $error("sync without enable held for the playback latency");

endmodule

bind spi_peripheral function_generator_chk u_chk_spi (
	.word_clock(word_clock),
	.reset3_word_clock(reset3_word_clock),
	.req(req),
	.ack(ack),
	.txn(txn),
	.enable(1'b0),
	.sync(1'b0)
);

bind playback_sequencer function_generator_chk u_chk_seq (
	.word_clock(word_clock),
	.reset3_word_clock(reset3_word_clock),
	.req(1'b0),
	.ack(1'b0),
	.txn('0),
	.enable(enable),
	.sync(sync)
);

/* testbench/tb_function_generator.sv */
/* Testbench for the SPI waveform generator. Runs the operations listed in the
   test file over SPI and checks reads and playback against a reference model. */
`timescale 1ns/1ps

module tb_function_generator
	import fgen_types_pkg::*, spi_frame_pkg::*;
();

	// word clocks per SPI half-period, and idle time between frames
	localparam int half_period = 8;
	localparam int frame_gap = 16;
	localparam int max_tests = 64;

	logic word_clock;
	logic reset3_word_clock;
	logic spi_sclk;
	logic spi_mosi;
	logic spi_ce0;
	logic spi_ce1;
	logic spi_miso;
	sample_t sample;
	logic sync;

	// reference model of memory and playback range
	word_t ref_mem [1024];
	sample_addr_t ref_start;
	sample_addr_t ref_end;
	word_t lcg_state;

	// test list as read from the file
	logic [8*24-1:0] test_name [max_tests];
	logic [8*12-1:0] test_op [max_tests];
	word_t test_a [max_tests];
	word_t test_b [max_tests];
	int test_count;
	longint budget_cycles;

	function_generator_top #(
		.SAMPLE_ADDR_WIDTH(12)
	) u_dut (
		.word_clock(word_clock),
		.reset3_word_clock(reset3_word_clock),
		.spi_sclk(spi_sclk),
		.spi_mosi(spi_mosi),
		.spi_ce0(spi_ce0),
		.spi_ce1(spi_ce1),
		.spi_miso(spi_miso),
		.sample(sample),
		.sync(sync)
	);

	always #10 word_clock = ~word_clock;

	// --------------------
	// failure reporting and compares
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic compare_word(input logic [8*24-1:0] name, input word_t expected,
		input word_t actual);
		if (actual !== expected) begin
			fail_run($sformatf("** Error %0s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	task automatic compare_sample(input logic [8*24-1:0] name, input sample_t expected,
		input sample_t actual);
		if (actual !== expected) begin
			fail_run($sformatf("** Error %0s: expected sample %h, actual %h", name, expected,
				actual));
		end
	endtask

	task automatic compare_sync(input logic [8*24-1:0] name, input logic expected,
		input logic actual);
		if (actual !== expected) begin
			fail_run($sformatf("** Error %0s: expected sync %b, actual %b", name, expected,
				actual));
		end
	endtask

	function automatic word_t lcg_next(input word_t state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// byte 0 of a word is the top byte and plays first
	function automatic sample_t model_sample(input sample_addr_t idx);
		word_t w;
		int lane;
		w = ref_mem[idx[11:2]];
		lane = int'(idx[1:0]);
		return w[31-8*lane -: 8];
	endfunction

	// inputs change 2 ns after the rising edge
	task automatic step_cycles(input int n);
		repeat (n) @(posedge word_clock);
		#2;
	endtask

	// --------------------
	// SPI host, mode 0, one 56-bit frame
	task automatic spi_frame(input logic sel_mem, input spi_txn_t frame, output word_t rx);
		logic [55:0] bits;
		int i;
		bits = frame;
		rx = '0;
		if (sel_mem) begin
			spi_ce1 = 1'b0;
		end else begin
			spi_ce0 = 1'b0;
		end
		for (i = 55; i >= 0; i--) begin
			spi_mosi = bits[i];
			step_cycles(half_period);
			spi_sclk = 1'b1;
			// data phase, read bits are valid at the rising edge
			if (i < 32) begin
				rx = {rx[30:0], spi_miso};
			end
			step_cycles(half_period);
			spi_sclk = 1'b0;
		end
		step_cycles(half_period);
		spi_ce0 = 1'b1;
		spi_ce1 = 1'b1;
		spi_mosi = 1'b0;
		step_cycles(frame_gap);
	endtask

	task automatic spi_write(input logic sel_mem, input spi_addr_t addr, input word_t data);
		spi_txn_t frame;
		word_t unused;
		frame.cmd = cmd_write;
		frame.addr = addr;
		frame.data = data;
		spi_frame(sel_mem, frame, unused);
	endtask

	task automatic spi_read(input logic sel_mem, input spi_addr_t addr, output word_t data);
		spi_txn_t frame;
		frame.cmd = cmd_read;
		frame.addr = addr;
		frame.data = '0;
		spi_frame(sel_mem, frame, data);
	endtask

	// --------------------
	// output observation
	task automatic quiet_check(input logic [8*24-1:0] name, input int count);
		int i;
		for (i = 0; i < count; i++) begin
			compare_sample(name, 8'h00, sample);
			compare_sync(name, 1'b0, sync);
			step_cycles(1);
		end
	endtask

	task automatic play_check(input logic [8*24-1:0] name, input int count);
		int i;
		int pos;
		int pass_len;
		sample_addr_t addr;
		pass_len = (ref_end > ref_start) ? int'(ref_end - ref_start) : 1;
		pos = 0;
		// align on the first sample of a pass
		while (sync !== 1'b1) begin
			step_cycles(1);
		end
		for (i = 0; i < count; i++) begin
			addr = ref_start + sample_addr_t'(pos);
			compare_sync(name, pos == 0, sync);
			compare_sample(name, model_sample(addr), sample);
			pos = (pos + 1) % pass_len;
			step_cycles(1);
		end
	endtask

	// --------------------
	// test file
	function automatic longint line_budget(input logic [8*12-1:0] op, input word_t a,
		input word_t b);
		if (op == "mem_fill" || op == "mem_verify") begin
			return 2000 + 1000 * longint'(b);
		end
		return 2000 + longint'(a);
	endfunction

	task automatic load_tests();
		int fd;
		int n;
		logic [8*128-1:0] line_buf;
		logic [8*24-1:0] name;
		logic [8*12-1:0] op;
		word_t a;
		word_t b;
		longint total;
		total = 0;
		fd = $fopen("testbench/fgen_tests.txt", "r");
		if (fd == 0) begin
			fail_run("could not open the test file testbench/fgen_tests.txt");
		end
		line_buf = '0;
		while ($fgets(line_buf, fd) != 0) begin
			name = '0;
			op = '0;
			n = $sscanf(line_buf, "%s %s %h %h", name, op, a, b);
			if (n == 4 && name != "#" && test_count < max_tests) begin
				test_name[test_count] = name;
				test_op[test_count] = op;
				test_a[test_count] = a;
				test_b[test_count] = b;
				total = total + line_budget(op, a, b);
				test_count++;
			end
			line_buf = '0;
		end
		$fclose(fd);
		if (test_count == 0) begin
			fail_run("the test file holds no test lines");
		end
		budget_cycles = total;
	endtask

	task automatic run_test(input int idx);
		logic [8*24-1:0] name;
		word_t a;
		word_t b;
		word_t rd;
		int i;
		name = test_name[idx];
		a = test_a[idx];
		b = test_b[idx];
		case (test_op[idx])
			"quiet": quiet_check(name, int'(a));
			"reg_write": begin
				spi_write(1'b0, a[15:0], b);
				if (a[1:0] == reg_start) begin
					ref_start = b[11:0];
				end else if (a[1:0] == reg_end) begin
					ref_end = b[11:0];
				end
			end
			"reg_read": begin
				spi_read(1'b0, a[15:0], rd);
				compare_word(name, b, rd);
			end
			"mem_write": begin
				spi_write(1'b1, a[15:0], b);
				ref_mem[a[9:0]] = b;
			end
			"mem_read": begin
				spi_read(1'b1, a[15:0], rd);
				compare_word(name, b, rd);
			end
			"mem_fill": begin
				for (i = 0; i < int'(b); i++) begin
					lcg_state = lcg_next(lcg_state);
					spi_write(1'b1, spi_addr_t'(a + word_t'(i)), lcg_state);
					ref_mem[word_addr_t'(a + word_t'(i))] = lcg_state;
				end
			end
			"mem_verify": begin
				for (i = 0; i < int'(b); i++) begin
					spi_read(1'b1, spi_addr_t'(a + word_t'(i)), rd);
					compare_word(name, ref_mem[word_addr_t'(a + word_t'(i))], rd);
				end
			end
			"play": play_check(name, int'(a));
			default: fail_run($sformatf("unknown operation %0s in test %0s", test_op[idx], name));
		endcase
	endtask

	// --------------------
	initial begin
		int i;
		word_clock = 1'b0;
		reset3_word_clock = 1'b1;
		spi_sclk = 1'b0;
		spi_mosi = 1'b0;
		spi_ce0 = 1'b1;
		spi_ce1 = 1'b1;
		ref_start = '0;
		ref_end = '0;
		lcg_state = 32'hd1a7;
		test_count = 0;
		load_tests();
		repeat (16) @(posedge word_clock);
		#2;
		reset3_word_clock = 1'b0;
		step_cycles(4);
		for (i = 0; i < test_count; i++) begin
			run_test(i);
		end
		step_cycles(8);
		$display("TB PASSED");
		$finish;
	end

	// watchdog, budget comes from the test list
	initial begin
		wait (budget_cycles > 0);
		repeat (budget_cycles) @(posedge word_clock);
		$display("timeout: the tests did not finish within %0d word clocks", budget_cycles);
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

/* testbench/fgen_tests.txt */
# columns: test name, operation, first field (hex), second field (hex)
# reads give address and expected word; quiet and play give a sample count
reset_quiet      quiet       40     0
reset_start      reg_read    0      00000000
reset_end        reg_read    1      00000000
reset_enable     reg_read    2      00000000
reset_unused     reg_read    3      00000000
reg_start_wr     reg_write   0      00000004
reg_end_wr       reg_write   1      00000013
reg_start_rd     reg_read    0      00000004
reg_end_rd       reg_read    1      00000013
reg_unused_wr    reg_write   3      deadbeef
reg_unused_rd    reg_read    3      00000000
mem_word0_wr     mem_write   0      00112233
mem_word0_rd     mem_read    0      00112233
mem_lcg_fill     mem_fill    1      8
mem_lcg_check    mem_verify  1      8
mem_top_wr       mem_write   3ff    a5c3e17f
mem_top_rd       mem_read    3ff    a5c3e17f
run_on           reg_write   2      00000001
run_enable_rd    reg_read    2      00000001
play_first       play        30     0
new_start        reg_write   0      00000010
new_end          reg_write   1      00000018
play_second      play        20     0
run_off          reg_write   2      00000000
stop_quiet       quiet       60     0

/* project.f */
logic/fgen_types_pkg.sv
logic/spi_frame_pkg.sv
logic/spi_peripheral.sv
logic/control_registers.sv
logic/waveform_memory.sv
logic/playback_sequencer.sv
logic/function_generator_top.sv
testbench/function_generator_chk.sv
testbench/tb_function_generator.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run, and decide pass or fail from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module tb_function_generator -o sim_fgen > build.log 2>&1 \
	|| { cat build.log; exit 1; }
./obj_dir/sim_fgen > sim.log 2>&1 || true
grep -q '^TB PASSED$' sim.log && echo "simulation passed" \
	|| { cat sim.log; echo "simulation failed"; exit 1; }
